// File: source/pong_config.svh
`ifndef PONG_CONFIG_SVH
`define PONG_CONFIG_SVH

// playfield frame on the 640x480 raster
`define FIELD_LEFT      20
`define FIELD_RIGHT     620
`define FIELD_TOP       20
`define FIELD_BOTTOM    460
`define LINE_THICK      6

// dashed middle line, x bounds inclusive
`define MID_X_LO        317
`define MID_X_HI        323
`define DASH_LEN        10
`define DASH_PITCH      20
`define DASH_FIRST      36   // first dash of upper half
`define DASH_CENTER     235  // single centre dash
`define DASH_LOWER      254  // first dash of lower half
`define DASH_COUNT_HALF 10

// goal opening on both sides
`define GOAL_TOP        130
`define GOAL_BOTTOM     350

// left edge of each paddle column
`define P1_MAIN_X       40
`define P1_FWD_X        484  // football forward, also squash bat
`define P2_MAIN_X       594
`define P2_FWD_X        150
`define P2_SQ_X         500

// object sizes
`define PADDLE_W        6
`define BALL_HALF       4
`define BAT_HALF_SMALL  15
`define BAT_HALF_LARGE  25

// game mode codes
`define MODE_TENNIS     0
`define MODE_FOOTBALL   1
`define MODE_SQUASH     2
`define MODE_PRACTICE   3

`endif

// File: source/pong_pkg.sv
`default_nettype none

package pong_pkg;

    // raster coordinate, same width for x and y
    typedef logic [10:0] coord_t;

    // game mode code
    typedef logic [1:0] mode_t;

    // paddle half height in lines
    typedef logic [5:0] half_size_t;

endpackage

`default_nettype wire

// File: source/field_cfg_if.sv
`timescale 1ns/10ps
`default_nettype none

interface field_cfg_if;
    import pong_pkg::*;

    logic       mid_line;
    logic       goal_left;
    logic       goal_right;
    logic       squash_wall;
    logic       p1_main;
    logic       p1_fwd;
    logic       p2_main;
    logic       p2_fwd;
    logic       p2_squash;
    half_size_t paddle_half;

    modport source (output mid_line, goal_left, goal_right, squash_wall,
                    output p1_main, p1_fwd, p2_main, p2_fwd, p2_squash, paddle_half);

    modport field (input mid_line, goal_left, goal_right, squash_wall);

    modport objects (input p1_main, p1_fwd, p2_main, p2_fwd, p2_squash, paddle_half);

endinterface

`default_nettype wire

// File: source/mode_decoder.sv
`timescale 1ns/10ps
`default_nettype none

`include "pong_config.svh"

module mode_decoder (
    input  wire                  clk,
    input  wire                  rst,
    input  wire pong_pkg::mode_t mode,
    input  wire                  bat_size,
    field_cfg_if.source          cfg
);
    import pong_pkg::*;

    logic       mid_line_nxt;
    logic       goal_left_nxt;
    logic       goal_right_nxt;
    logic       squash_wall_nxt;
    logic       p1_main_nxt;
    logic       p1_fwd_nxt;
    logic       p2_main_nxt;
    logic       p2_fwd_nxt;
    logic       p2_squash_nxt;
    half_size_t half_nxt;

    always_comb begin
        mid_line_nxt    = 1'b0;
        goal_left_nxt   = 1'b0;
        goal_right_nxt  = 1'b0;
        squash_wall_nxt = 1'b0;
        p1_main_nxt     = 1'b0;
        p1_fwd_nxt      = 1'b0;
        p2_main_nxt     = 1'b0;
        p2_fwd_nxt      = 1'b0;
        p2_squash_nxt   = 1'b0;
        case (mode)
            mode_t'(`MODE_TENNIS): begin
                mid_line_nxt = 1'b1;
                p1_main_nxt  = 1'b1;
                p2_main_nxt  = 1'b1;
            end
            mode_t'(`MODE_FOOTBALL): begin
                mid_line_nxt   = 1'b1;
                goal_left_nxt  = 1'b1;
                goal_right_nxt = 1'b1;
                p1_main_nxt    = 1'b1;
                p1_fwd_nxt     = 1'b1;
                p2_main_nxt    = 1'b1;
                p2_fwd_nxt     = 1'b1;
            end
            mode_t'(`MODE_SQUASH): begin
                goal_left_nxt   = 1'b1;
                squash_wall_nxt = 1'b1;
                p1_fwd_nxt      = 1'b1;
                p2_squash_nxt   = 1'b1;
            end
            default: begin // practice against the wall
                goal_left_nxt   = 1'b1;
                squash_wall_nxt = 1'b1;
                p1_fwd_nxt      = 1'b1;
            end
        endcase
    end

    assign half_nxt = bat_size ? half_size_t'(`BAT_HALF_SMALL) : half_size_t'(`BAT_HALF_LARGE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cfg.mid_line    <= 1'b0;
            cfg.goal_left   <= 1'b0;
            cfg.goal_right  <= 1'b0;
            cfg.squash_wall <= 1'b0;
            cfg.p1_main     <= 1'b0;
            cfg.p1_fwd      <= 1'b0;
            cfg.p2_main     <= 1'b0;
            cfg.p2_fwd      <= 1'b0;
            cfg.p2_squash   <= 1'b0;
            cfg.paddle_half <= '0;
        end else begin
            cfg.mid_line    <= mid_line_nxt;
            cfg.goal_left   <= goal_left_nxt;
            cfg.goal_right  <= goal_right_nxt;
            cfg.squash_wall <= squash_wall_nxt;
            cfg.p1_main     <= p1_main_nxt;
            cfg.p1_fwd      <= p1_fwd_nxt;
            cfg.p2_main     <= p2_main_nxt;
            cfg.p2_fwd      <= p2_fwd_nxt;
            cfg.p2_squash   <= p2_squash_nxt;
            cfg.paddle_half <= half_nxt;
        end
    end

    // right player owns at most one bat on the right side
    a_p2_one_bat: assert property (@(posedge clk) disable iff (rst)
        !(cfg.p2_main && cfg.p2_squash));

    // only the two bat sizes once out of reset
    a_half_legal: assert property (@(posedge clk) disable iff (rst)
        !$past(rst) |-> (cfg.paddle_half == half_size_t'(`BAT_HALF_SMALL) ||
                         cfg.paddle_half == half_size_t'(`BAT_HALF_LARGE)));

endmodule

`default_nettype wire

// File: source/field_renderer.sv
`timescale 1ns/10ps
`default_nettype none

`include "pong_config.svh"

module field_renderer (
    input  wire pong_pkg::coord_t x,
    input  wire pong_pkg::coord_t y,
    field_cfg_if.field            cfg,
    output logic                  field_px
);
    import pong_pkg::*;

    logic left_strip;
    logic right_strip;
    logic outside_goal;
    logic boundary;
    logic mid_col;
    logic dash_row;
    logic goals;
    logic wall;

    // lower bound inclusive, upper bound exclusive
    function automatic logic in_range(coord_t v, coord_t lo, coord_t hi);
        return (v >= lo) && (v < hi);
    endfunction

    assign left_strip  = in_range(x, coord_t'(`FIELD_LEFT),
                                  coord_t'(`FIELD_LEFT + `LINE_THICK));
    assign right_strip = in_range(x, coord_t'(`FIELD_RIGHT - `LINE_THICK),
                                  coord_t'(`FIELD_RIGHT));

    // top and bottom walls across the whole width
    assign boundary = in_range(x, coord_t'(`FIELD_LEFT), coord_t'(`FIELD_RIGHT)) &&
                      (in_range(y, coord_t'(`FIELD_TOP), coord_t'(`FIELD_TOP + `LINE_THICK)) ||
                       in_range(y, coord_t'(`FIELD_BOTTOM - `LINE_THICK),
                                coord_t'(`FIELD_BOTTOM)));

    assign mid_col = in_range(x, coord_t'(`MID_X_LO), coord_t'(`MID_X_HI + 1));

    always_comb begin
        dash_row = in_range(y, coord_t'(`DASH_CENTER), coord_t'(`DASH_CENTER + `DASH_LEN));
        for (int i = 0; i < `DASH_COUNT_HALF; i++) begin
            if (in_range(y, coord_t'(`DASH_FIRST + i * `DASH_PITCH),
                         coord_t'(`DASH_FIRST + i * `DASH_PITCH + `DASH_LEN))) begin
                dash_row = 1'b1; // upper half
            end
            if (in_range(y, coord_t'(`DASH_LOWER + i * `DASH_PITCH),
                         coord_t'(`DASH_LOWER + i * `DASH_PITCH + `DASH_LEN))) begin
                dash_row = 1'b1; // lower half
            end
        end
    end

    // side lines stop at the goal mouth
    assign outside_goal = in_range(y, coord_t'(`FIELD_TOP), coord_t'(`GOAL_TOP)) ||
                          in_range(y, coord_t'(`GOAL_BOTTOM), coord_t'(`FIELD_BOTTOM));

    assign goals = outside_goal && ((cfg.goal_left && left_strip) ||
                                    (cfg.goal_right && right_strip));

    // squash closes the left goal mouth
    assign wall = cfg.squash_wall && left_strip &&
                  in_range(y, coord_t'(`GOAL_TOP), coord_t'(`GOAL_BOTTOM));

    assign field_px = boundary || (cfg.mid_line && mid_col && dash_row) || goals || wall;

endmodule

`default_nettype wire

// File: source/object_overlay.sv
`timescale 1ns/10ps
`default_nettype none

`include "pong_config.svh"

module object_overlay (
    input  wire                   clk,
    input  wire                   rst,
    input  wire pong_pkg::coord_t x,
    input  wire pong_pkg::coord_t y,
    input  wire pong_pkg::coord_t p1_y,
    input  wire pong_pkg::coord_t p2_y,
    input  wire pong_pkg::coord_t ball_x,
    input  wire pong_pkg::coord_t ball_y,
    input  wire                   field_px,
    field_cfg_if.objects          cfg,
    output logic                  px_data
);
    import pong_pkg::*;

    coord_t half;
    logic   p1_rows;
    logic   p2_rows;
    logic   p1_hit;
    logic   p2_hit;
    logic   sq_col;
    logic   ball_hit;
    logic   px_nxt;

    // paddle column, PADDLE_W wide from its left edge
    function automatic logic in_col(coord_t v, coord_t left);
        return (v >= left) && (v < left + coord_t'(`PADDLE_W));
    endfunction

    assign half = coord_t'(cfg.paddle_half);

    assign p1_rows = (y >= p1_y - half) && (y < p1_y + half);
    assign p2_rows = (y >= p2_y - half) && (y < p2_y + half);

    // squash bat has a two pixel slot in the middle
    assign sq_col = in_col(x, coord_t'(`P2_SQ_X)) &&
                    (x != coord_t'(`P2_SQ_X + 2)) && (x != coord_t'(`P2_SQ_X + 3));

    assign p1_hit = p1_rows && ((cfg.p1_main && in_col(x, coord_t'(`P1_MAIN_X))) ||
                                (cfg.p1_fwd && in_col(x, coord_t'(`P1_FWD_X))));

    assign p2_hit = p2_rows && ((cfg.p2_main && in_col(x, coord_t'(`P2_MAIN_X))) ||
                                (cfg.p2_fwd && in_col(x, coord_t'(`P2_FWD_X))) ||
                                (cfg.p2_squash && sq_col));

    // ball is always on, no enable
    assign ball_hit = (x >= ball_x - coord_t'(`BALL_HALF)) &&
                      (x < ball_x + coord_t'(`BALL_HALF)) &&
                      (y >= ball_y - coord_t'(`BALL_HALF)) &&
                      (y < ball_y + coord_t'(`BALL_HALF));

    assign px_nxt = field_px || p1_hit || p2_hit || ball_hit;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            px_data <= 1'b0;
        end else begin
            px_data <= px_nxt;
        end
    end

    a_px_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(px_data));

endmodule

`default_nettype wire

// File: source/video_encoder.sv
`timescale 1ns/10ps
`default_nettype none

module video_encoder (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   bat_size,
    input  wire pong_pkg::mode_t  mode,
    input  wire pong_pkg::coord_t p1_y,
    input  wire pong_pkg::coord_t p2_y,
    input  wire pong_pkg::coord_t ball_x,
    input  wire pong_pkg::coord_t ball_y,
    input  wire pong_pkg::coord_t x,
    input  wire pong_pkg::coord_t y,
    output logic                  px_data
);

    logic field_px; // static lines only

    field_cfg_if cfg_bus ();

    mode_decoder i_mode_decoder (
        .clk      (clk),
        .rst      (rst),
        .mode     (mode),
        .bat_size (bat_size),
        .cfg      (cfg_bus.source)
    );

    field_renderer i_field_renderer (
        .x        (x),
        .y        (y),
        .cfg      (cfg_bus.field),
        .field_px (field_px)
    );

    object_overlay i_object_overlay (
        .clk      (clk),
        .rst      (rst),
        .x        (x),
        .y        (y),
        .p1_y     (p1_y),
        .p2_y     (p2_y),
        .ball_x   (ball_x),
        .ball_y   (ball_y),
        .field_px (field_px),
        .cfg      (cfg_bus.objects),
        .px_data  (px_data)
    );

endmodule

`default_nettype wire

// File: verification/video_encoder_tb.sv
`timescale 1ns/10ps
`default_nettype none

module video_encoder_tb;
    import pong_pkg::*;

    localparam time CLK_PERIOD = 100ns;
    localparam int  MAX_CASES  = 64;

    logic   clk;
    logic   rst;
    logic   bat_size;
    mode_t  mode;
    coord_t p1_y;
    coord_t p2_y;
    coord_t ball_x;
    coord_t ball_y;
    coord_t x;
    coord_t y;
    logic   px_data;

    logic loaded = 1'b0;
    int   num_cases;
    int   pass_count;
    int   fail_count;
    int   vec [0:MAX_CASES-1][0:9]; // test, mode, bat, p1, p2, bx, by, x, y, px

    video_encoder i_video_encoder (
        .clk      (clk),
        .rst      (rst),
        .bat_size (bat_size),
        .mode     (mode),
        .p1_y     (p1_y),
        .p2_y     (p2_y),
        .ball_x   (ball_x),
        .ball_y   (ball_y),
        .x        (x),
        .y        (y),
        .px_data  (px_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic load_cases();
        int    fd;
        int    n;
        string line;
        num_cases = 0;
        fd = $fopen("verification/video_encoder_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open the case file");
            fail_count++;
            return;
        end
        while (!$feof(fd) && num_cases < MAX_CASES) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() > 1 && line.getc(0) != "#") begin // skip comments
                n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d",
                            vec[num_cases][0], vec[num_cases][1], vec[num_cases][2],
                            vec[num_cases][3], vec[num_cases][4], vec[num_cases][5],
                            vec[num_cases][6], vec[num_cases][7], vec[num_cases][8],
                            vec[num_cases][9]);
                if (n == 10) begin
                    num_cases++;
                end
            end
        end
        $fclose(fd);
        if (num_cases == 0) begin
            $display("the case file holds no test cases");
            fail_count++;
        end
    endtask

    task automatic check_pixel(input int test, input int expected);
        if (px_data !== expected[0]) begin
            $display("Fail at %0t: test %0d px_data expected %0d, got %b",
                     $time, test, expected, px_data);
            fail_count++;
        end else begin
            $display("test %0d passed", test);
            pass_count++;
        end
    endtask

    // watchdog armed once the case count is known
    initial begin
        wait (loaded);
        #((num_cases * 4 + 20) * CLK_PERIOD);
        $display("run timed out after %0d clock periods", num_cases * 4 + 20);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        int i;
        int prev_mode;
        int prev_bat;
        clk        = 1'b0;
        rst        = 1'b1;
        bat_size   = 1'b0;
        mode       = '0;
        p1_y       = 11'd240;
        p2_y       = 11'd240;
        ball_x     = 11'd100;
        ball_y     = 11'd100;
        x          = '0;
        y          = '0;
        pass_count = 0;
        fail_count = 0;
        load_cases();
        loaded = 1'b1;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        check_pixel(0, 0); // still the reset value
        prev_mode = -1;
        prev_bat  = -1;
        for (i = 0; i < num_cases; i++) begin
            mode     = mode_t'(vec[i][1]);
            bat_size = vec[i][2][0];
            p1_y     = coord_t'(vec[i][3]);
            p2_y     = coord_t'(vec[i][4]);
            ball_x   = coord_t'(vec[i][5]);
            ball_y   = coord_t'(vec[i][6]);
            x        = coord_t'(vec[i][7]);
            y        = coord_t'(vec[i][8]);
            if (vec[i][1] != prev_mode || vec[i][2] != prev_bat) begin
                repeat (2) @(negedge clk); // let the mode registers settle
            end
            @(posedge clk);
            @(negedge clk);
            check_pixel(vec[i][0], vec[i][9]);
            prev_mode = vec[i][1];
            prev_bat  = vec[i][2];
        end
        $display("passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/video_encoder_cases.txt
# test mode bat_size p1_y p2_y ball_x ball_y x y px_data
# decimal values, mode 0 tennis, 1 football, 2 squash, 3 practice
1 0 0 240 240 100 100 20 20 1
2 0 0 240 240 100 100 300 19 0
3 0 0 240 240 100 100 620 22 0
4 0 0 240 240 100 100 300 460 0
5 0 0 240 240 100 100 317 36 1
6 0 0 240 240 100 100 320 46 0
7 0 0 240 240 100 100 320 235 1
8 0 0 240 240 100 100 40 220 1
9 0 0 240 240 100 100 96 96 1
10 0 1 240 240 100 100 40 220 0
11 0 1 240 240 100 100 40 225 1
12 1 0 240 240 100 100 20 100 1
13 1 0 240 240 100 100 22 130 0
14 1 0 240 240 100 100 614 26 1
15 1 0 240 240 100 100 150 264 1
16 1 0 240 240 100 100 619 459 1
17 2 0 240 240 100 100 103 103 1
18 2 0 240 240 100 100 20 240 1
19 2 0 240 240 100 100 320 36 0
20 2 0 240 240 100 100 502 240 0
21 2 0 240 240 100 100 504 240 1
22 3 0 240 240 100 100 104 100 0
23 3 0 240 240 100 100 484 240 1
24 3 0 240 240 100 100 500 240 0
25 3 0 240 240 100 100 300 454 1
26 3 0 240 240 100 100 100 95 0

// File: filelist.f
+incdir+source
source/pong_pkg.sv
source/field_cfg_if.sv
source/mode_decoder.sv
source/field_renderer.sv
source/object_overlay.sv
source/video_encoder.sv
verification/video_encoder_tb.sv

// File: Bender.yml
package:
  name: video_encoder

sources:
  - include_dirs:
      - source
    files:
      - source/pong_pkg.sv
      - source/field_cfg_if.sv
      - source/mode_decoder.sv
      - source/field_renderer.sv
      - source/object_overlay.sv
      - source/video_encoder.sv
  - target: test
    files:
      - verification/video_encoder_tb.sv
